// File: logic/cp0RegPkg.sv
/*
 * Coprocessor-0 register definitions
 * Register numbers, Status and Cause field positions,
 * interrupt line counts and reset constants
 */

package cp0RegPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    typedef logic [regAddrWidth-1:0] regAddr;
    typedef logic [dataWidth-1:0]    regWord;

    // Register numbers, select 0 only
    localparam regAddr addrBadVAddr = 5'd8;
    localparam regAddr addrCount    = 5'd9;
    localparam regAddr addrCompare  = 5'd11;
    localparam regAddr addrStatus   = 5'd12;
    localparam regAddr addrCause    = 5'd13;
    localparam regAddr addrEpc      = 5'd14;
    localparam regAddr addrPrid     = 5'd15;

    // Status fields
    localparam int statusBevBit = 22;
    localparam int statusImLsb  = 8;    // IM7..IM0
    localparam int statusExlBit = 1;
    localparam int statusIeBit  = 0;

    // Cause fields
    localparam int causeBdBit  = 31;
    localparam int causeTiBit  = 30;
    localparam int causeCeLsb  = 28;    // Two-bit coprocessor number
    localparam int causeIpLsb  = 8;     // IP7..IP0
    localparam int causeExcLsb = 2;

    // Hardware interrupts
    localparam int numHwInt     = 6;
    localparam int timerIntLine = 5;    // Lands on IP7

    localparam regWord pridValue    = 32'h0000_4220;
    localparam regWord compareReset = '1;

endpackage

// File: logic/excPkg.sv
/*
 * Exception definitions
 * Pipeline exception type encoding, architectural
 * ExcCode values and the BadVAddr source select
 */

package excPkg;

    localparam int excTypeWidth = 5;

    // Exception type as it arrives from the memory stage
    typedef enum logic [excTypeWidth-1:0] {
        excNone,
        excRefetch,
        excInterrupt,
        excAddrFetch,
        excAddrLoad,
        excAddrStore,
        excSyscall,
        excBreak,
        excReserved,
        excCpU,
        excOverflow,
        excTrap,
        excEret
    } excType;

    typedef logic [4:0] excCode;

    localparam excCode codeInt  = 5'd0;
    localparam excCode codeAdEL = 5'd4;
    localparam excCode codeAdES = 5'd5;
    localparam excCode codeSys  = 5'd8;
    localparam excCode codeBp   = 5'd9;
    localparam excCode codeRI   = 5'd10;
    localparam excCode codeCpU  = 5'd11;
    localparam excCode codeOv   = 5'd12;
    localparam excCode codeTr   = 5'd13;

    // Where BadVAddr is loaded from
    typedef enum logic [1:0] {
        srcNone,
        srcPc,
        srcData
    } badAddrSrc;

endpackage

// File: logic/excDecode.sv
/*
 * Exception type decoder
 * Maps the pipeline exception type to taken/eret flags,
 * an architectural ExcCode and the BadVAddr source
 */

`timescale 1ns/1ps

module excDecode (
    input  excPkg::excType    excTypeIn,
    output logic              excTaken,
    output logic              isEret,
    output logic              codeValid,
    output logic              isCpU,
    output excPkg::excCode    excCodeOut,
    output excPkg::badAddrSrc badSrc
);

    import excPkg::*;

    // Refetch only flushes, it never reaches CP0 state
    assign excTaken = (excTypeIn != excNone) && (excTypeIn != excRefetch);
    assign isEret   = (excTypeIn == excEret);
    assign isCpU    = (excTypeIn == excCpU);

    always_comb begin
        codeValid  = 1'b1;
        excCodeOut = codeInt;
        badSrc     = srcNone;
        case (excTypeIn)
            excInterrupt: excCodeOut = codeInt;
            excAddrFetch: begin
                excCodeOut = codeAdEL;
                badSrc     = srcPc;         // Misaligned fetch
            end
            excAddrLoad: begin
                excCodeOut = codeAdEL;
                badSrc     = srcData;
            end
            excAddrStore: begin
                excCodeOut = codeAdES;
                badSrc     = srcData;
            end
            excSyscall:   excCodeOut = codeSys;
            excBreak:     excCodeOut = codeBp;
            excReserved:  excCodeOut = codeRI;
            excCpU:       excCodeOut = codeCpU;
            excOverflow:  excCodeOut = codeOv;
            excTrap:      excCodeOut = codeTr;
            default: begin
                // None, refetch and eret leave ExcCode alone
                codeValid  = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/cp0Timer.sv
/*
 * Count and Compare registers
 * Count advances every second clock, Compare is
 * software loaded, match is flagged while equal
 */

`timescale 1ns/1ps

module cp0Timer (
    input  logic              clk,
    input  logic              reset,
    input  logic              wrEn,
    input  cp0RegPkg::regAddr wrAddr,
    input  cp0RegPkg::regWord wrData,
    output cp0RegPkg::regWord count,
    output cp0RegPkg::regWord compare,
    output logic              timerMatch
);

    import cp0RegPkg::*;

    logic countWr;
    logic compareWr;
    logic phase;        // Half-rate tick

    assign countWr   = wrEn && (wrAddr == addrCount);
    assign compareWr = wrEn && (wrAddr == addrCompare);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= 1'b0;
            count <= '0;
        end else if (countWr) begin
            phase <= 1'b0;
            count <= wrData;
        end else begin
            phase <= ~phase;
            if (phase)
                count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            compare <= compareReset;
        else if (compareWr)
            compare <= wrData;
    end

    assign timerMatch = (count == compare);

endmodule

// File: logic/cp0StatusCause.sv
/*
 * Status and Cause registers
 * Status BEV/IM/EXL/IE, Cause BD/TI/CE/IP/ExcCode,
 * with exception, eret and software write priority
 */

`timescale 1ns/1ps

module cp0StatusCause (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wrEn,
    input  cp0RegPkg::regAddr              wrAddr,
    input  cp0RegPkg::regWord              wrData,
    input  logic [cp0RegPkg::numHwInt-1:0] hwInt,
    input  logic                           timerMatch,
    input  logic                           excTaken,
    input  logic                           isEret,
    input  logic                           codeValid,
    input  logic                           isCpU,
    input  excPkg::excCode                 excCodeOut,
    input  logic                           excInDelaySlot,
    output logic                           statusBev,
    output logic [7:0]                     statusIm,
    output logic                           statusExl,
    output logic                           statusIe,
    output cp0RegPkg::regWord              causeWord
);

    import cp0RegPkg::*;
    import excPkg::*;

    logic                statusWr;
    logic                causeWr;
    logic                compareWr;
    logic                causeBd;
    logic                causeTi;
    logic                causeCe;   // Only coprocessor 1 is ever reported
    logic [numHwInt-1:0] ipHigh;    // IP7..IP2
    logic [1:0]          ipLow;     // Software interrupts
    excCode              causeExc;

    assign statusWr  = wrEn && (wrAddr == addrStatus);
    assign causeWr   = wrEn && (wrAddr == addrCause);
    assign compareWr = wrEn && (wrAddr == addrCompare);

    always_ff @(posedge clk) begin
        if (reset) begin
            statusBev <= 1'b1;
            statusIm  <= '0;
            statusIe  <= 1'b0;
        end else if (statusWr) begin
            statusBev <= wrData[statusBevBit];
            statusIm  <= wrData[statusImLsb +: 8];
            statusIe  <= wrData[statusIeBit];
        end
    end

    // Exception or eret beats a Status write on the same edge
    always_ff @(posedge clk) begin
        if (reset)
            statusExl <= 1'b0;
        else if (excTaken)
            statusExl <= !isEret;
        else if (statusWr)
            statusExl <= wrData[statusExlBit];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            causeBd  <= 1'b0;
            causeTi  <= 1'b0;
            causeCe  <= 1'b0;
            ipHigh   <= '0;
            ipLow    <= '0;
            causeExc <= '0;
        end else begin
            if (excTaken && !isEret && !statusExl)
                causeBd <= excInDelaySlot;  // Nested exceptions keep first BD
            if (compareWr)
                causeTi <= 1'b0;
            else if (timerMatch)
                causeTi <= 1'b1;
            if (isCpU)
                causeCe <= 1'b1;
            ipHigh <= hwInt | (numHwInt'(causeTi) << timerIntLine);
            if (causeWr)
                ipLow <= wrData[causeIpLsb +: 2];
            if (codeValid)
                causeExc <= excCodeOut;
        end
    end

    always_comb begin
        causeWord                              = '0;
        causeWord[causeBdBit]                  = causeBd;
        causeWord[causeTiBit]                  = causeTi;
        causeWord[causeCeLsb]                  = causeCe;
        causeWord[causeIpLsb +: 2]             = ipLow;
        causeWord[causeIpLsb + 2 +: numHwInt]  = ipHigh;
        causeWord[causeExcLsb +: $bits(causeExc)] = causeExc;
    end

endmodule

// File: logic/cp0ExcRecorder.sv
/*
 * EPC and BadVAddr
 * EPC captures the faulting pc with delay-slot correction,
 * BadVAddr captures the failing fetch or data address
 */

`timescale 1ns/1ps

module cp0ExcRecorder (
    input  logic              clk,
    input  logic              reset,
    input  logic              wrEn,
    input  cp0RegPkg::regAddr wrAddr,
    input  cp0RegPkg::regWord wrData,
    input  logic              excTaken,
    input  logic              isEret,
    input  excPkg::badAddrSrc badSrc,
    input  logic              statusExl,
    input  cp0RegPkg::regWord excPc,
    input  logic              excInDelaySlot,
    input  cp0RegPkg::regWord excDataAddr,
    output cp0RegPkg::regWord epc,
    output cp0RegPkg::regWord badVAddr
);

    import cp0RegPkg::*;
    import excPkg::*;

    // Any taken exception owns EPC this edge, eret simply holds it
    always_ff @(posedge clk) begin
        if (reset) begin
            epc <= '0;
        end else if (excTaken) begin
            if (!isEret && !statusExl)
                epc <= excInDelaySlot ? excPc - 32'd4 : excPc;  // Point at the branch
        end else if (wrEn && (wrAddr == addrEpc)) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            badVAddr <= '0;
        else if (badSrc == srcPc)
            badVAddr <= excPc;
        else if (badSrc == srcData)
            badVAddr <= excDataAddr;
    end

endmodule

// File: logic/cp0ReadMux.sv
/*
 * CP0 read port
 * Builds the Status word and returns the addressed
 * register, PRId constant or zero
 */

`timescale 1ns/1ps

module cp0ReadMux (
    input  cp0RegPkg::regAddr rdAddr,
    input  cp0RegPkg::regWord count,
    input  cp0RegPkg::regWord compare,
    input  cp0RegPkg::regWord causeWord,
    input  cp0RegPkg::regWord epc,
    input  cp0RegPkg::regWord badVAddr,
    input  logic              statusBev,
    input  logic [7:0]        statusIm,
    input  logic              statusExl,
    input  logic              statusIe,
    output cp0RegPkg::regWord rdData
);

    import cp0RegPkg::*;

    regWord statusWord;

    always_comb begin
        statusWord                     = '0;
        statusWord[statusBevBit]       = statusBev;
        statusWord[statusImLsb +: 8]   = statusIm;
        statusWord[statusExlBit]       = statusExl;
        statusWord[statusIeBit]        = statusIe;
    end

    always_comb begin
        case (rdAddr)
            addrBadVAddr: rdData = badVAddr;
            addrCount:    rdData = count;
            addrCompare:  rdData = compare;
            addrStatus:   rdData = statusWord;
            addrCause:    rdData = causeWord;
            addrEpc:      rdData = epc;
            addrPrid:     rdData = pridValue;
            default:      rdData = '0;      // Unimplemented registers
        endcase
    end

endmodule

// File: logic/cp0Top.sv
/*
 * Coprocessor-0 top level
 * Connects exception decoder, timer, Status/Cause,
 * EPC/BadVAddr recorder and the read multiplexer
 */

`timescale 1ns/1ps

module cp0Top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cp0RegPkg::numHwInt-1:0]    hwInt,
    input  logic                              wrEn,
    input  cp0RegPkg::regAddr                 wrAddr,
    input  cp0RegPkg::regWord                 wrData,
    input  cp0RegPkg::regAddr                 rdAddr,
    output cp0RegPkg::regWord                 rdData,
    input  excPkg::excType                    excTypeIn,
    input  cp0RegPkg::regWord                 excPc,
    input  logic                              excInDelaySlot,
    input  cp0RegPkg::regWord                 excDataAddr,
    output logic                              statusBev,
    output logic                              statusExl,
    output logic                              statusIe,
    output logic [7:0]                        statusIm,
    output logic [7:0]                        causeIp,
    output cp0RegPkg::regWord                 epc
);

    import cp0RegPkg::*;
    import excPkg::*;

    logic      excTaken;
    logic      isEret;
    logic      codeValid;
    logic      isCpU;
    excCode    excCodeOut;
    badAddrSrc badSrc;

    logic      timerMatch;
    regWord    count;
    regWord    compare;
    regWord    causeWord;
    regWord    badVAddr;

    assign causeIp = causeWord[causeIpLsb +: 8];

    excDecode decoder (
        .excTypeIn  (excTypeIn),
        .excTaken   (excTaken),
        .isEret     (isEret),
        .codeValid  (codeValid),
        .isCpU      (isCpU),
        .excCodeOut (excCodeOut),
        .badSrc     (badSrc)
    );

    cp0Timer timer (
        .clk        (clk),
        .reset      (reset),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .count      (count),
        .compare    (compare),
        .timerMatch (timerMatch)
    );

    cp0StatusCause statusCause (
        .clk            (clk),
        .reset          (reset),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData),
        .hwInt          (hwInt),
        .timerMatch     (timerMatch),
        .excTaken       (excTaken),
        .isEret         (isEret),
        .codeValid      (codeValid),
        .isCpU          (isCpU),
        .excCodeOut     (excCodeOut),
        .excInDelaySlot (excInDelaySlot),
        .statusBev      (statusBev),
        .statusIm       (statusIm),
        .statusExl      (statusExl),
        .statusIe       (statusIe),
        .causeWord      (causeWord)
    );

    cp0ExcRecorder recorder (
        .clk            (clk),
        .reset          (reset),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData),
        .excTaken       (excTaken),
        .isEret         (isEret),
        .badSrc         (badSrc),
        .statusExl      (statusExl),
        .excPc          (excPc),
        .excInDelaySlot (excInDelaySlot),
        .excDataAddr    (excDataAddr),
        .epc            (epc),
        .badVAddr       (badVAddr)
    );

    cp0ReadMux readMux (
        .rdAddr    (rdAddr),
        .count     (count),
        .compare   (compare),
        .causeWord (causeWord),
        .epc       (epc),
        .badVAddr  (badVAddr),
        .statusBev (statusBev),
        .statusIm  (statusIm),
        .statusExl (statusExl),
        .statusIe  (statusIe),
        .rdData    (rdData)
    );

endmodule

// File: dv/cp0Tb.sv
/*
 * Testbench for the coprocessor-0 block
 * Clock and reset, register and exception stimulus tasks,
 * assertion checks, watchdog and result summary
 */

`timescale 1ns/1ps

module cp0Tb;

    import cp0RegPkg::*;
    import excPkg::*;

    localparam int clkPeriod   = 20;
    // Cycle budget per test
    localparam int resetCycles = 10;
    localparam int maskCycles  = 40;
    localparam int timerCycles = 40;
    localparam int intCycles   = 15;
    localparam int excCycles   = 25;
    localparam int addrCycles  = 15;
    localparam int totalCycles = resetCycles + maskCycles + timerCycles
                               + intCycles + excCycles + addrCycles;

    logic                clk;
    logic                reset;
    logic [numHwInt-1:0] hwInt;
    logic                wrEn;
    regAddr              wrAddr;
    regWord              wrData;
    regAddr              rdAddr;
    regWord              rdData;
    excType              excTypeIn;
    regWord              excPc;
    logic                excInDelaySlot;
    regWord              excDataAddr;
    logic                statusBev;
    logic                statusExl;
    logic                statusIe;
    logic [7:0]          statusIm;
    logic [7:0]          causeIp;
    regWord              epc;

    int errorCount;
    int checkCount;
    int testCount;
    int testStartErrors;

    cp0Top dut (
        .clk            (clk),
        .reset          (reset),
        .hwInt          (hwInt),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData),
        .rdAddr         (rdAddr),
        .rdData         (rdData),
        .excTypeIn      (excTypeIn),
        .excPc          (excPc),
        .excInDelaySlot (excInDelaySlot),
        .excDataAddr    (excDataAddr),
        .statusBev      (statusBev),
        .statusExl      (statusExl),
        .statusIe       (statusIe),
        .statusIm       (statusIm),
        .causeIp        (causeIp),
        .epc            (epc)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(totalCycles * 2 * clkPeriod);
        $display("Timeout: run did not finish within %0d cycles", totalCycles * 2);
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic checkValue(input string name, input regWord expected, input regWord actual);
        checkCount++;
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic endTest(input string name);
        testCount++;
        $display("Test %-8s %s, %0d errors", name,
                 (errorCount == testStartErrors) ? "ok" : "failed",
                 errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    // Write lands on the second edge
    task automatic writeReg(input regAddr addr, input regWord data);
        @(posedge clk);
        wrEn   <= 1'b1;
        wrAddr <= addr;
        wrData <= data;
        @(posedge clk);
        wrEn   <= 1'b0;
    endtask

    task automatic readReg(input regAddr addr, output regWord value);
        @(posedge clk);
        rdAddr <= addr;
        @(negedge clk);
        value = rdData;     // Settled mid-cycle
    endtask

    task automatic raiseExc(input excType kind, input regWord pc, input logic delaySlot,
                            input regWord dataAddr);
        @(posedge clk);
        excTypeIn      <= kind;
        excPc          <= pc;
        excInDelaySlot <= delaySlot;
        excDataAddr    <= dataAddr;
        @(posedge clk);
        excTypeIn      <= excNone;
        excInDelaySlot <= 1'b0;
    endtask

    initial begin
        regWord              value;
        regWord              word;
        regWord              pc;
        regWord              c;
        regWord              savedEpc;
        int                  k;
        logic [numHwInt-1:0] lines;
        bit                  timerSeen;

        errorCount      = 0;
        checkCount      = 0;
        testCount       = 0;
        testStartErrors = 0;
        void'($urandom(32'h8e32677f));

        reset          = 1'b1;
        hwInt          = '0;
        wrEn           = 1'b0;
        wrAddr         = '0;
        wrData         = '0;
        rdAddr         = '0;
        excTypeIn      = excNone;
        excPc          = '0;
        excInDelaySlot = 1'b0;
        excDataAddr    = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        readReg(addrStatus, value);
        checkValue("reset/status", 32'h0040_0000, value);
        checkValue("reset/bev", 1, statusBev);
        checkValue("reset/exl", 0, statusExl);
        checkValue("reset/ie", 0, statusIe);
        readReg(addrCause, value);
        checkValue("reset/cause", 0, value);
        readReg(addrCompare, value);
        checkValue("reset/compare", 32'hffff_ffff, value);
        endTest("reset");

        // Only BEV, IM, EXL and IE are writable in Status
        word = $urandom();
        writeReg(addrStatus, word);
        readReg(addrStatus, value);
        checkValue("mask/status", word & 32'h0040_ff03, value);
        checkValue("mask/im", word[15:8], statusIm);
        writeReg(addrStatus, 32'h0040_0000);
        word = $urandom();
        writeReg(addrCause, word);
        readReg(addrCause, value);
        checkValue("mask/cause", word & 32'h0000_0300, value);
        word = $urandom();
        writeReg(addrEpc, word);
        readReg(addrEpc, value);
        checkValue("mask/epc", word, value);
        word = $urandom();
        writeReg(addrCompare, word);
        readReg(addrCompare, value);
        checkValue("mask/compare", word, value);
        writeReg(addrBadVAddr, $urandom());
        readReg(addrBadVAddr, value);
        checkValue("mask/badVAddr", 0, value);     // Read-only
        writeReg(addrPrid, $urandom());
        readReg(addrPrid, value);
        checkValue("mask/prid", 32'h0000_4220, value);
        readReg(5'd3, value);
        checkValue("mask/unused", 0, value);
        endTest("mask");

        c = $urandom();
        k = $urandom_range(8, 1);
        writeReg(addrCount, c);
        writeReg(addrCompare, c + regWord'(k));
        rdAddr <= addrCause;
        timerSeen = 1'b0;
        for (int i = 0; i < 2 * k + 4 && !timerSeen; i++) begin
            @(negedge clk);
            if (rdData[30] && causeIp[7])
                timerSeen = 1'b1;
        end
        assert (timerSeen) else begin
            $display("Timer interrupt did not appear within %0d cycles", 2 * k + 4);
            errorCount++;
        end
        checkValue("timer/ti", 1, rdData[30]);
        checkValue("timer/ip7", 1, causeIp[7]);
        writeReg(addrCompare, c - 32'd100);   // Far behind Count
        @(negedge clk);
        checkValue("timer/clear", 0, rdData[30]);
        endTest("timer");

        // TI was cleared by the Compare write, so IP7 is the line alone
        repeat (4) begin
            lines = numHwInt'($urandom());
            @(posedge clk);
            hwInt <= lines;
            @(posedge clk);
            @(negedge clk);
            checkValue("irq/ip", lines, causeIp[7:2]);
        end
        @(posedge clk);
        hwInt <= '0;
        endTest("irq");

        pc = $urandom() & 32'hffff_fffc;
        raiseExc(excSyscall, pc, 1'b1, 32'h0);
        savedEpc = pc - 32'd4;
        readReg(addrEpc, value);
        checkValue("exc/sysEpc", savedEpc, value);
        checkValue("exc/sysEpcOut", savedEpc, epc);
        readReg(addrCause, value);
        checkValue("exc/sysBd", 1, value[31]);
        checkValue("exc/sysCode", 8, value[6:2]);
        checkValue("exc/sysExl", 1, statusExl);
        // Nested, EXL already set
        raiseExc(excOverflow, $urandom() & 32'hffff_fffc, 1'b0, 32'h0);
        readReg(addrCause, value);
        checkValue("exc/ovCode", 12, value[6:2]);
        checkValue("exc/ovBd", 1, value[31]);
        readReg(addrEpc, value);
        checkValue("exc/ovEpc", savedEpc, value);
        raiseExc(excEret, $urandom(), 1'b0, 32'h0);
        readReg(addrEpc, value);
        checkValue("exc/eretEpc", savedEpc, value);
        checkValue("exc/eretExl", 0, statusExl);
        raiseExc(excCpU, $urandom(), 1'b0, 32'h0);
        readReg(addrCause, value);
        checkValue("exc/cpuCe", 1, value[29:28]);
        checkValue("exc/cpuCode", 11, value[6:2]);
        endTest("exc");

        pc = $urandom();
        raiseExc(excAddrFetch, pc, 1'b0, 32'h0);
        readReg(addrBadVAddr, value);
        checkValue("addr/fetchBad", pc, value);
        readReg(addrCause, value);
        checkValue("addr/fetchCode", 4, value[6:2]);
        word = $urandom();
        raiseExc(excAddrStore, $urandom(), 1'b0, word);
        readReg(addrBadVAddr, value);
        checkValue("addr/storeBad", word, value);
        readReg(addrCause, value);
        checkValue("addr/storeCode", 5, value[6:2]);
        endTest("addr");

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: sources.f
logic/cp0RegPkg.sv
logic/excPkg.sv
logic/excDecode.sv
logic/cp0Timer.sv
logic/cp0StatusCause.sv
logic/cp0ExcRecorder.sv
logic/cp0ReadMux.sv
logic/cp0Top.sv
dv/cp0Tb.sv
